// File: hw/xpu_rx_pkg.sv
// shared rx header constants; byte indices count from the first MPDU octet, fields are little endian
package xpu_rx_pkg;

  // phy byte counter width
  localparam int BYTE_IDX_W = 16;

  typedef logic [47:0] mac_addr_t; // first octet on air sits in bits 7:0

  // first MPDU byte of each header field
  localparam logic [BYTE_IDX_W-1:0] FC_FIRST_BYTE    = BYTE_IDX_W'(0);
  localparam logic [BYTE_IDX_W-1:0] DUR_FIRST_BYTE   = BYTE_IDX_W'(2);
  localparam logic [BYTE_IDX_W-1:0] ADDR1_FIRST_BYTE = BYTE_IDX_W'(4);
  localparam logic [BYTE_IDX_W-1:0] ADDR2_FIRST_BYTE = BYTE_IDX_W'(10);
  localparam logic [BYTE_IDX_W-1:0] ADDR3_FIRST_BYTE = BYTE_IDX_W'(16);

  localparam logic [BYTE_IDX_W-1:0] ADDR_BYTES = BYTE_IDX_W'(6); // octets per address

  // complete addresses seen so far, 0 to 3
  localparam int ADDR_CNT_W = 2;

  // filter config bits
  localparam int FILTER_CFG_W    = 5;
  localparam int FLT_ALL_BIT     = 0; // pass everything
  localparam int FLT_UNICAST_BIT = 1; // addr1 is self
  localparam int FLT_BCAST_BIT   = 2; // addr1 is broadcast
  localparam int FLT_BSSID_BIT   = 3; // addr3 is own bss
  localparam int FLT_BAD_FCS_BIT = 4; // let fcs errors through

  // header records held between parser and filter
  localparam int RX_FIFO_DEPTH = 4;

endpackage

// File: hw/rx_hdr_if.sv
// one parsed header record with valid/ready; fields must hold steady while valid waits for ready
`timescale 1ns/100ps

interface rx_hdr_if;
  import xpu_rx_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [15:0]           fc;       // frame control
  logic [15:0]           duration;
  mac_addr_t             addr1;    // receiver
  mac_addr_t             addr2;    // transmitter
  mac_addr_t             addr3;
  logic [ADDR_CNT_W-1:0] addr_cnt; // complete addresses in the record
  logic                  fcs_ok;

  modport src (
    output valid, fc, duration, addr1, addr2, addr3, addr_cnt, fcs_ok,
    input  ready
  );

  modport dst (
    input  valid, fc, duration, addr1, addr2, addr3, addr_cnt, fcs_ok,
    output ready
  );

endinterface

// File: hw/mac_hdr_parse.sv
// parses fc, duration and addr1..3 only; a frame ending while a record still waits is dropped
`timescale 1ns/100ps

module mac_hdr_parse (
  input  logic                              s00_axi_aclk,
  input  logic                              rst_n_i,
  input  logic [7:0]                        byte_in_i,
  input  logic                              byte_in_strobe_i,
  input  logic [xpu_rx_pkg::BYTE_IDX_W-1:0] byte_count_i,
  input  logic                              pkt_header_valid_strobe_i,
  input  logic                              fcs_in_strobe_i,
  input  logic                              fcs_ok_i,
  rx_hdr_if.src                             hdr_o,
  output logic [7:0]                        drop_cnt_o
);
  import xpu_rx_pkg::*;

  localparam logic [BYTE_IDX_W-1:0] ADDR_LAST_OFF = ADDR_BYTES - BYTE_IDX_W'(1);
  localparam logic [BYTE_IDX_W-1:0] ADDR_FIRST [3] =
    '{ADDR1_FIRST_BYTE, ADDR2_FIRST_BYTE, ADDR3_FIRST_BYTE};

  // frame under reception
  logic [15:0]           fc_q;
  logic [15:0]           dur_q;
  mac_addr_t             addr_q [3];
  logic [ADDR_CNT_W-1:0] addr_cnt_q;
  logic [BYTE_IDX_W-1:0] fc_off;
  logic [BYTE_IDX_W-1:0] dur_off;
  logic [BYTE_IDX_W-1:0] addr_off [3];

  // record handed to the queue
  logic                  hold_vld_q;
  logic [15:0]           hold_fc_q;
  logic [15:0]           hold_dur_q;
  mac_addr_t             hold_addr_q [3];
  logic [ADDR_CNT_W-1:0] hold_cnt_q;
  logic                  hold_fcs_ok_q;
  logic                  fire;

  // offsets wrap to large values below the field start, so one compare per field
  always_comb begin
    fc_off  = byte_count_i - FC_FIRST_BYTE;
    dur_off = byte_count_i - DUR_FIRST_BYTE;
    for (int i = 0; i < 3; i++) begin
      addr_off[i] = byte_count_i - ADDR_FIRST[i];
    end
  end

  always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fc_q       <= '0;
      dur_q      <= '0;
      addr_cnt_q <= '0;
      for (int i = 0; i < 3; i++) begin
        addr_q[i] <= '0;
      end
    end else if (pkt_header_valid_strobe_i) begin // new frame starts from zero
      fc_q       <= '0;
      dur_q      <= '0;
      addr_cnt_q <= '0;
      for (int i = 0; i < 3; i++) begin
        addr_q[i] <= '0;
      end
    end else if (byte_in_strobe_i) begin
      if (fc_off[BYTE_IDX_W-1:1] == '0) begin
        fc_q[{fc_off[0], 3'b000} +: 8] <= byte_in_i;
      end
      if (dur_off[BYTE_IDX_W-1:1] == '0) begin
        dur_q[{dur_off[0], 3'b000} +: 8] <= byte_in_i;
      end
      for (int i = 0; i < 3; i++) begin
        if (addr_off[i] < ADDR_BYTES) begin
          addr_q[i][{addr_off[i][2:0], 3'b000} +: 8] <= byte_in_i;
          if (addr_off[i] == ADDR_LAST_OFF) begin
            addr_cnt_q <= ADDR_CNT_W'(i + 1); // address complete
          end
        end
      end
    end
  end

  assign fire = hdr_o.valid && hdr_o.ready;

  always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_vld_q    <= 1'b0;
      hold_fc_q     <= '0;
      hold_dur_q    <= '0;
      hold_cnt_q    <= '0;
      hold_fcs_ok_q <= 1'b0;
      drop_cnt_o    <= '0;
      for (int i = 0; i < 3; i++) begin
        hold_addr_q[i] <= '0;
      end
    end else if (fcs_in_strobe_i && hold_vld_q && !hdr_o.ready) begin
      if (drop_cnt_o != 8'hff) begin
        drop_cnt_o <= drop_cnt_o + 8'd1; // saturating
      end
    end else if (fcs_in_strobe_i) begin
      hold_vld_q    <= 1'b1;
      hold_fc_q     <= fc_q;
      hold_dur_q    <= dur_q;
      hold_cnt_q    <= addr_cnt_q;
      hold_fcs_ok_q <= fcs_ok_i;
      hold_addr_q   <= addr_q;
    end else if (fire) begin
      hold_vld_q <= 1'b0;
    end
  end

  assign hdr_o.valid    = hold_vld_q;
  assign hdr_o.fc       = hold_fc_q;
  assign hdr_o.duration = hold_dur_q;
  assign hdr_o.addr1    = hold_addr_q[0];
  assign hdr_o.addr2    = hold_addr_q[1];
  assign hdr_o.addr3    = hold_addr_q[2];
  assign hdr_o.addr_cnt = hold_cnt_q;
  assign hdr_o.fcs_ok   = hold_fcs_ok_q;

  // queue back-pressure must never disturb a waiting record
  hold_stable_a: assert property (@(posedge s00_axi_aclk) disable iff (!rst_n_i)
    hdr_o.valid && !hdr_o.ready |=> hdr_o.valid && $stable({hdr_o.fc, hdr_o.duration,
      hdr_o.addr1, hdr_o.addr2, hdr_o.addr3, hdr_o.addr_cnt, hdr_o.fcs_ok}));

endmodule

// File: hw/rx_hdr_fifo.sv
// in-order header queue of RX_FIFO_DEPTH records; output is taken straight from the storage array
`timescale 1ns/100ps

module rx_hdr_fifo (
  input  logic  s00_axi_aclk,
  input  logic  rst_n_i,
  rx_hdr_if.dst wr,
  rx_hdr_if.src rd
);
  import xpu_rx_pkg::*;

  localparam int PTR_W = $clog2(RX_FIFO_DEPTH);
  localparam int CNT_W = $clog2(RX_FIFO_DEPTH + 1);

  typedef struct packed {
    logic [15:0]           fc;
    logic [15:0]           duration;
    mac_addr_t             addr1;
    mac_addr_t             addr2;
    mac_addr_t             addr3;
    logic [ADDR_CNT_W-1:0] addr_cnt;
    logic                  fcs_ok;
  } hdr_rec_t;

  hdr_rec_t         mem [RX_FIFO_DEPTH];
  hdr_rec_t         rd_rec;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;   // records stored
  logic             wr_fire;
  logic             rd_fire;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(RX_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr.ready = (cnt_q != CNT_W'(RX_FIFO_DEPTH)); // low only when full
  assign wr_fire  = wr.valid && wr.ready;
  assign rd.valid = (cnt_q != '0);
  assign rd_fire  = rd.valid && rd.ready;

  always_ff @(posedge s00_axi_aclk) begin
    if (wr_fire) begin
      mem[wr_ptr_q] <= {wr.fc, wr.duration, wr.addr1, wr.addr2, wr.addr3, wr.addr_cnt, wr.fcs_ok};
    end
  end

  always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_fire) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (rd_fire) rd_ptr_q <= ptr_next(rd_ptr_q);
      if (wr_fire && !rd_fire) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign rd_rec      = mem[rd_ptr_q];
  assign rd.fc       = rd_rec.fc;
  assign rd.duration = rd_rec.duration;
  assign rd.addr1    = rd_rec.addr1;
  assign rd.addr2    = rd_rec.addr2;
  assign rd.addr3    = rd_rec.addr3;
  assign rd.addr_cnt = rd_rec.addr_cnt;
  assign rd.fcs_ok   = rd_rec.fcs_ok;

  cnt_bound_a: assert property (@(posedge s00_axi_aclk) disable iff (!rst_n_i)
    cnt_q <= CNT_W'(RX_FIFO_DEPTH));

  // full and not drained, so nothing may land next cycle
  full_no_wr_a: assert property (@(posedge s00_axi_aclk) disable iff (!rst_n_i)
    cnt_q == CNT_W'(RX_FIFO_DEPTH) && !rd_fire |=> cnt_q == CNT_W'(RX_FIFO_DEPTH)
      && $stable(wr_ptr_q));

endmodule

// File: hw/rx_filter.sv
// address filter with one output register; the bssid rule needs all three addresses
`timescale 1ns/100ps

module rx_filter (
  input  logic                                s00_axi_aclk,
  input  logic                                rst_n_i,
  rx_hdr_if.dst                               hdr_i,
  input  xpu_rx_pkg::mac_addr_t               self_mac_addr_i,
  input  xpu_rx_pkg::mac_addr_t               self_bssid_i,
  input  logic [xpu_rx_pkg::FILTER_CFG_W-1:0] filter_cfg_i,
  output logic                                rx_valid_o,
  input  logic                                rx_ready_i,
  output logic [15:0]                         fc_o,
  output logic [15:0]                         duration_o,
  output xpu_rx_pkg::mac_addr_t               addr1_o,
  output xpu_rx_pkg::mac_addr_t               addr2_o,
  output logic                                pkt_for_me_o,
  output logic                                block_rx_dma_o
);
  import xpu_rx_pkg::*;

  logic has_addr1;
  logic for_me;
  logic is_bcast;
  logic is_bss;
  logic cfg_match;
  logic pass;
  logic take;

  assign has_addr1 = (hdr_i.addr_cnt != '0);
  assign for_me    = has_addr1 && (hdr_i.addr1 == self_mac_addr_i);
  assign is_bcast  = has_addr1 && (hdr_i.addr1 == '1);
  assign is_bss    = (hdr_i.addr_cnt == ADDR_CNT_W'(3)) && (hdr_i.addr3 == self_bssid_i);

  always_comb begin
    cfg_match = filter_cfg_i[FLT_ALL_BIT]
             || (filter_cfg_i[FLT_UNICAST_BIT] && for_me)
             || (filter_cfg_i[FLT_BCAST_BIT] && is_bcast)
             || (filter_cfg_i[FLT_BSSID_BIT] && is_bss);
    pass = (hdr_i.fcs_ok || filter_cfg_i[FLT_BAD_FCS_BIT]) && cfg_match;
  end

  // take a new record when empty or being drained this cycle
  assign hdr_i.ready = !rx_valid_o || rx_ready_i;
  assign take        = hdr_i.valid && hdr_i.ready;

  always_ff @(posedge s00_axi_aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_valid_o     <= 1'b0;
      fc_o           <= '0;
      duration_o     <= '0;
      addr1_o        <= '0;
      addr2_o        <= '0;
      pkt_for_me_o   <= 1'b0;
      block_rx_dma_o <= 1'b0;
    end else if (take) begin
      rx_valid_o     <= 1'b1;
      fc_o           <= hdr_i.fc;
      duration_o     <= hdr_i.duration;
      addr1_o        <= hdr_i.addr1;
      addr2_o        <= hdr_i.addr2; // zero on short frames
      pkt_for_me_o   <= for_me;
      block_rx_dma_o <= !pass;
    end else if (rx_ready_i) begin
      rx_valid_o <= 1'b0; // drained
    end
  end

  out_stable_a: assert property (@(posedge s00_axi_aclk) disable iff (!rst_n_i)
    rx_valid_o && !rx_ready_i |=> rx_valid_o && $stable({fc_o, duration_o, addr1_o,
      addr2_o, pkt_for_me_o, block_rx_dma_o}));

endmodule

// File: hw/xpu_rx_top.sv
// rx header path top; holds RX_FIFO_DEPTH + 2 records under back-pressure, further frames count as drops
`timescale 1ns/100ps

module xpu_rx_top (
  input  logic                                s00_axi_aclk,
  input  logic                                rst_n_i,
  // phy byte stream
  input  logic [7:0]                          byte_in_i,
  input  logic                                byte_in_strobe_i,
  input  logic [xpu_rx_pkg::BYTE_IDX_W-1:0]   byte_count_i,
  input  logic                                pkt_header_valid_strobe_i,
  input  logic                                fcs_in_strobe_i,
  input  logic                                fcs_ok_i,
  // filter setup, static during traffic
  input  xpu_rx_pkg::mac_addr_t               self_mac_addr_i,
  input  xpu_rx_pkg::mac_addr_t               self_bssid_i,
  input  logic [xpu_rx_pkg::FILTER_CFG_W-1:0] filter_cfg_i,
  // filtered header out
  output logic                                rx_valid_o,
  input  logic                                rx_ready_i,
  output logic [15:0]                         fc_o,
  output logic [15:0]                         duration_o,
  output xpu_rx_pkg::mac_addr_t               addr1_o,
  output xpu_rx_pkg::mac_addr_t               addr2_o,
  output logic                                pkt_for_me_o,
  output logic                                block_rx_dma_o,
  output logic [7:0]                          drop_cnt_o
);

  rx_hdr_if hdr_raw ();  // parser to queue
  rx_hdr_if hdr_q ();    // queue to filter

  mac_hdr_parse u_mac_hdr_parse (
    .s00_axi_aclk              (s00_axi_aclk),
    .rst_n_i                   (rst_n_i),
    .byte_in_i                 (byte_in_i),
    .byte_in_strobe_i          (byte_in_strobe_i),
    .byte_count_i              (byte_count_i),
    .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
    .fcs_in_strobe_i           (fcs_in_strobe_i),
    .fcs_ok_i                  (fcs_ok_i),
    .hdr_o                     (hdr_raw.src),
    .drop_cnt_o                (drop_cnt_o)
  );

  rx_hdr_fifo u_rx_hdr_fifo (
    .s00_axi_aclk (s00_axi_aclk),
    .rst_n_i      (rst_n_i),
    .wr           (hdr_raw.dst),
    .rd           (hdr_q.src)
  );

  rx_filter u_rx_filter (
    .s00_axi_aclk    (s00_axi_aclk),
    .rst_n_i         (rst_n_i),
    .hdr_i           (hdr_q.dst),
    .self_mac_addr_i (self_mac_addr_i),
    .self_bssid_i    (self_bssid_i),
    .filter_cfg_i    (filter_cfg_i),
    .rx_valid_o      (rx_valid_o),
    .rx_ready_i      (rx_ready_i),
    .fc_o            (fc_o),
    .duration_o      (duration_o),
    .addr1_o         (addr1_o),
    .addr2_o         (addr2_o),
    .pkt_for_me_o    (pkt_for_me_o),
    .block_rx_dma_o  (block_rx_dma_o)
  );

endmodule

// File: verification/tb_xpu_rx.sv
// self address and bssid stay fixed; the filter config only changes while the pipeline is empty
`timescale 1ns/100ps

module tb_xpu_rx;
  import xpu_rx_pkg::*;

  localparam mac_addr_t SELF_MAC  = 48'h5a_34_12_de_c0_02;
  localparam mac_addr_t BSSID     = 48'h77_66_55_44_33_22;
  localparam int        FRAME_MAX = 40;
  localparam int        WAIT_LIMIT = 2000;
  localparam int        STORE_CNT = RX_FIFO_DEPTH + 2; // queue, parser hold, filter reg

  typedef struct packed {
    logic [15:0] fc;
    logic [15:0] duration;
    mac_addr_t   addr1;
    mac_addr_t   addr2;
    logic        for_me;
    logic        block;
  } exp_rec_t;

  logic                    clk = 1'b0;
  logic                    rst_n_i = 1'b0;
  logic [7:0]              byte_in_i = '0;
  logic                    byte_in_strobe_i = 1'b0;
  logic [BYTE_IDX_W-1:0]   byte_count_i = '0;
  logic                    pkt_header_valid_strobe_i = 1'b0;
  logic                    fcs_in_strobe_i = 1'b0;
  logic                    fcs_ok_i = 1'b0;
  logic [FILTER_CFG_W-1:0] filter_cfg_i = '0;
  logic                    rx_ready_i = 1'b1;
  logic                    rx_valid_o;
  logic [15:0]             fc_o;
  logic [15:0]             duration_o;
  mac_addr_t               addr1_o;
  mac_addr_t               addr2_o;
  logic                    pkt_for_me_o;
  logic                    block_rx_dma_o;
  logic [7:0]              drop_cnt_o;

  logic [31:0] rng_state = 32'hacf0;
  logic [7:0]  frm [FRAME_MAX]; // frame being sent
  int          frm_len = 0;
  int          ready_mode = 0;  // 0 high, 1 low, 2 random
  exp_rec_t    exp_q [$];
  int          out_cnt = 0;
  int          mismatch_cnt = 0;
  int          timeout_cnt = 0;
  int          other_cnt = 0;

  xpu_rx_top u_xpu_rx_top (
    .s00_axi_aclk              (clk),
    .rst_n_i                   (rst_n_i),
    .byte_in_i                 (byte_in_i),
    .byte_in_strobe_i          (byte_in_strobe_i),
    .byte_count_i              (byte_count_i),
    .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
    .fcs_in_strobe_i           (fcs_in_strobe_i),
    .fcs_ok_i                  (fcs_ok_i),
    .self_mac_addr_i           (SELF_MAC),
    .self_bssid_i              (BSSID),
    .filter_cfg_i              (filter_cfg_i),
    .rx_valid_o                (rx_valid_o),
    .rx_ready_i                (rx_ready_i),
    .fc_o                      (fc_o),
    .duration_o                (duration_o),
    .addr1_o                   (addr1_o),
    .addr2_o                   (addr2_o),
    .pkt_for_me_o              (pkt_for_me_o),
    .block_rx_dma_o            (block_rx_dma_o),
    .drop_cnt_o                (drop_cnt_o)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // byte as the receiver saw it, zero when never sent
  function automatic logic [7:0] rx_byte(input int idx);
    return (idx < frm_len) ? frm[idx] : 8'h00;
  endfunction

  // expected record for the frame in frm
  function automatic exp_rec_t predict(input logic [FILTER_CFG_W-1:0] cfg, input logic good);
    exp_rec_t  e;
    mac_addr_t a3;
    int        cnt;
    logic      match;
    e.fc       = {rx_byte(1), rx_byte(0)};
    e.duration = {rx_byte(3), rx_byte(2)};
    for (int k = 0; k < 6; k++) begin
      e.addr1[8*k +: 8] = rx_byte(4 + k);
      e.addr2[8*k +: 8] = rx_byte(10 + k);
      a3[8*k +: 8]      = rx_byte(16 + k);
    end
    cnt = (frm_len >= 22) ? 3 : (frm_len >= 16) ? 2 : (frm_len >= 10) ? 1 : 0;
    e.for_me = (cnt >= 1) && (e.addr1 == SELF_MAC);
    match = cfg[FLT_ALL_BIT] || (cfg[FLT_UNICAST_BIT] && e.for_me)
         || (cfg[FLT_BCAST_BIT] && cnt >= 1 && e.addr1 == 48'hffff_ffff_ffff)
         || (cfg[FLT_BSSID_BIT] && cnt == 3 && a3 == BSSID);
    e.block = !((good || cfg[FLT_BAD_FCS_BIT]) && match);
    return e;
  endfunction

  // self, broadcast, bssid or anything
  function automatic mac_addr_t pick_addr();
    logic [31:0] r;
    logic [31:0] lo;
    r  = next_rand();
    lo = next_rand();
    case (r[1:0])
      2'd0:    return SELF_MAC;
      2'd1:    return 48'hffff_ffff_ffff;
      2'd2:    return BSSID;
      default: return {r[31:16], lo};
    endcase
  endfunction

  function automatic int pick_len();
    logic [31:0] r;
    r = next_rand();
    if (r[1:0] == 2'd0) return 10; // ack sized
    if (r[1:0] == 2'd1) return 16;
    return 22 + int'(r[31:8] % 24'd19);
  endfunction

  task automatic report_mismatch(input string what, input logic [47:0] got,
                                 input logic [47:0] want);
    mismatch_cnt++;
    $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
  endtask

  task automatic send_frame(input logic [15:0] fc, input logic [15:0] dur, input mac_addr_t a1,
                            input mac_addr_t a2, input mac_addr_t a3, input int len,
                            input logic good, input bit keep);
    logic [31:0] r;
    for (int k = 0; k < 2; k++) begin
      frm[k]     = fc[8*k +: 8];
      frm[2 + k] = dur[8*k +: 8];
    end
    for (int k = 0; k < 6; k++) begin
      frm[4 + k]  = a1[8*k +: 8];
      frm[10 + k] = a2[8*k +: 8];
      frm[16 + k] = a3[8*k +: 8];
    end
    for (int k = 22; k < FRAME_MAX; k++) begin
      r      = next_rand();
      frm[k] = r[7:0]; // body bytes
    end
    frm_len = len;
    @(negedge clk);
    pkt_header_valid_strobe_i = 1'b1;
    @(negedge clk);
    pkt_header_valid_strobe_i = 1'b0;
    for (int i = 0; i < len; i++) begin
      r = next_rand();
      if (r[2:0] == 3'd0) begin
        byte_in_strobe_i = 1'b0; // phy gap
        @(negedge clk);
      end
      byte_in_i        = frm[i];
      byte_count_i     = BYTE_IDX_W'(i);
      byte_in_strobe_i = 1'b1;
      @(negedge clk);
    end
    byte_in_strobe_i = 1'b0;
    fcs_ok_i         = good;
    fcs_in_strobe_i  = 1'b1;
    if (keep) exp_q.push_back(predict(filter_cfg_i, good));
    @(negedge clk);
    fcs_in_strobe_i = 1'b0;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || rx_valid_o) && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0 || rx_valid_o) begin
      timeout_cnt++;
      $display("timeout at %0t: %0d records never came out", $time, exp_q.size());
    end
  endtask

  always @(negedge clk) begin
    logic [31:0] r;
    r = next_rand();
    if (ready_mode == 2) rx_ready_i <= r[0];
    else rx_ready_i <= (ready_mode == 0);
  end

  // scoreboard, one pop per output transfer
  always @(posedge clk) begin
    exp_rec_t want;
    if (rst_n_i && rx_valid_o && rx_ready_i) begin
      out_cnt++;
      if (exp_q.size() == 0) begin
        other_cnt++;
        $display("error at %0t: output record with no frame waiting for it", $time);
      end else begin
        want = exp_q.pop_front();
        if (fc_o != want.fc) report_mismatch("fc", fc_o, want.fc);
        if (duration_o != want.duration) report_mismatch("duration", duration_o, want.duration);
        if (addr1_o != want.addr1) report_mismatch("addr1", addr1_o, want.addr1);
        if (addr2_o != want.addr2) report_mismatch("addr2", addr2_o, want.addr2);
        if (pkt_for_me_o != want.for_me) report_mismatch("pkt_for_me", pkt_for_me_o, want.for_me);
        if (block_rx_dma_o != want.block) report_mismatch("block", block_rx_dma_o, want.block);
      end
    end
  end

  initial begin
    logic [31:0] r;
    int          base;
    repeat (16) @(negedge clk);
    rst_n_i = 1'b1;
    repeat (4) @(negedge clk);

    // unicast to self, good fcs
    filter_cfg_i = FILTER_CFG_W'(1 << FLT_UNICAST_BIT);
    send_frame(16'h0208, 16'h002c, SELF_MAC, 48'h0a_0b_0c_0d_0e_0f, BSSID, 24, 1'b1, 1'b1);
    wait_drained();

    // ack length frame never passes on bssid
    filter_cfg_i = FILTER_CFG_W'((1 << FLT_BSSID_BIT) | (1 << FLT_BAD_FCS_BIT));
    send_frame(16'h00d4, 16'h0000, SELF_MAC, 48'h11_22_33_44_55_66, BSSID, 10, 1'b1, 1'b1);
    wait_drained();

    for (int n = 0; n < 200; n++) begin
      r = next_rand();
      filter_cfg_i = r[FILTER_CFG_W-1:0];
      send_frame(r[15:0], r[31:16], pick_addr(), pick_addr(), pick_addr(), pick_len(),
                 r[9:8] != 2'b00, 1'b1);
      wait_drained();
    end

    // random back-pressure, spaced frames
    ready_mode = 2;
    filter_cfg_i = FILTER_CFG_W'(1 << FLT_ALL_BIT);
    for (int n = 0; n < 30; n++) begin
      r = next_rand();
      send_frame(r[15:0], r[31:16], pick_addr(), pick_addr(), pick_addr(), pick_len(),
                 r[5], 1'b1);
      repeat (40) @(negedge clk);
    end
    wait_drained();
    if (drop_cnt_o != 8'd0) report_mismatch("drop_cnt", drop_cnt_o, 8'd0);

    // stalled output, only the stored records survive
    ready_mode = 1;
    repeat (2) @(negedge clk);
    base = out_cnt;
    for (int n = 0; n < 9; n++) begin
      r = next_rand();
      send_frame(r[15:0], r[31:16], pick_addr(), pick_addr(), pick_addr(), 24, 1'b1,
                 n < STORE_CNT);
      repeat (10) @(negedge clk);
    end
    if (drop_cnt_o != 8'(9 - STORE_CNT)) report_mismatch("drop_cnt", drop_cnt_o, 9 - STORE_CNT);
    ready_mode = 0;
    wait_drained();
    repeat (20) @(negedge clk);
    if (out_cnt - base != STORE_CNT) report_mismatch("records out", out_cnt - base, STORE_CNT);

    $display("errors: %0d mismatch, %0d timeout, %0d other", mismatch_cnt, timeout_cnt,
             other_cnt);
    if (mismatch_cnt + timeout_cnt + other_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
hw/xpu_rx_pkg.sv
hw/rx_hdr_if.sv
hw/mac_hdr_parse.sv
hw/rx_hdr_fifo.sv
hw/rx_filter.sv
hw/xpu_rx_top.sv
verification/tb_xpu_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the rx header testbench with Verilator, run it and judge the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_xpu_rx \
  -f flist.f -o tb_xpu_rx
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_xpu_rx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
  echo "simulation log has no final verdict"
  exit 1
fi
exit 0
